//--- src.f
hdl/pcnt_cfg_pkg.sv
hdl/pcnt_data_pkg.sv
hdl/pulse_edge_sync.sv
hdl/gate_timer.sv
hdl/bcd_counter.sv
hdl/window_capture.sv
hdl/pulse_counter_top.sv
bench/tb_clock_gen.sv
bench/pulse_counter_asserts.sv
bench/pulse_counter_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module pulse_counter_tb \
    -f src.f -o pulse_counter_sim

./obj_dir/pulse_counter_sim > sim.log 2>&1
cat sim.log

if grep -qF '*** FAILED ***' sim.log; then
    exit 1
fi
exit 0

//--- bench/pulse_counter_tb.sv
`timescale 1ns/1ps

module pulse_counter_tb;

    localparam int win_len      = 4000;
    localparam int num_digits   = 3;
    // pulse high to pulse_event, in cycles.
    localparam int sync_latency = 3;
    // keep events this far from update and clear.
    localparam int guard        = 10;
    localparam int slack        = 100;
    // windows per test, 2 + 1 + 3 + 2 + 3.
    localparam int run_cycles      = 11 * win_len + 5 * slack;
    localparam int watchdog_cycles = run_cycles * 12 / 10;

    logic                          clk;
    logic                          rst_n;
    logic                          en;
    logic                          pulse;
    pcnt_data_pkg::decimal_count_t window_count;
    pcnt_data_pkg::decimal_count_t total_count;
    pcnt_data_pkg::window_record_t record;
    logic                          record_update;

    // cycle index since en rose, and the reference model.
    int          pos;
    int          win_edges[8];
    int          total_edges;
    int          errors;
    int          checks;
    logic [31:0] lfsr_state;

    tb_clock_gen clock_gen_inst (
        .clk   (clk),
        .rst_n (rst_n)
    );

    pulse_counter_top #(
        .window_cycles (win_len),
        .num_digits    (num_digits)
    ) pulse_counter_top_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .en            (en),
        .pulse         (pulse),
        .window_count  (window_count),
        .total_count   (total_count),
        .record        (record),
        .record_update (record_update)
    );

    bind pulse_counter_top pulse_counter_asserts asserts_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .en            (en),
        .window_count  (window_count),
        .total_count   (total_count),
        .record_update (record_update)
    );

    ////////////////////
    // helpers
    ////////////////////

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    // value modulo 10^num_digits as display digits.
    function automatic pcnt_data_pkg::decimal_count_t expect_decimal(input int value,
                                                                     input logic ovf);
        pcnt_data_pkg::decimal_count_t d;
        int v;
        d = '0;
        v = value;
        for (int i = 0; i < num_digits; i++) begin
            d.display.digit[i] = 4'(v % 10);
            v = v / 10;
        end
        d.ovf = ovf;
        return d;
    endfunction

    function automatic pcnt_data_pkg::window_record_t expect_record(input int tally,
                                                                    input int seq,
                                                                    input logic ovf);
        pcnt_data_pkg::window_record_t r;
        r.tally = 16'(tally);
        r.seq   = 16'(seq);
        r.ovf   = ovf;
        return r;
    endfunction

    task automatic check_decimal(input string name, input pcnt_data_pkg::decimal_count_t got,
                                 input pcnt_data_pkg::decimal_count_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_record(input string name, input pcnt_data_pkg::window_record_t got,
                                input pcnt_data_pkg::window_record_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_cycle(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("Fail at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic step();
        @(posedge clk);
        pos = pos + 1;
    endtask

    // en low for a few cycles, then a fresh window starts at pos 0.
    task automatic start_enable();
        step();
        en <= 1'b0;
        repeat (3) step();
        en <= 1'b1;
        pos = 0;
        total_edges = 0;
        foreach (win_edges[i]) begin
            win_edges[i] = 0;
        end
    endtask

    // pulses inside the current window, clear of its boundary strobes.
    task automatic drive_burst(input int max_pulses, input int fixed_gap);
        int w;
        int ev;
        int gap;
        int sent;
        sent = 0;
        step();
        w = pos / win_len;
        while (((pos + sync_latency) % win_len) < guard) begin
            step();
        end
        while (sent < max_pulses) begin
            ev = pos + sync_latency;
            if ((ev / win_len) != w || (ev % win_len) > (win_len - 2 - guard)) begin
                break;
            end
            pulse <= 1'b1;
            step();
            pulse <= 1'b0;
            win_edges[w] = win_edges[w] + 1;
            total_edges = total_edges + 1;
            sent = sent + 1;
            if (fixed_gap > 0) begin
                gap = fixed_gap;
            end else begin
                gap = 2 + rand_bits(3);
            end
            repeat (gap) step();
        end
    endtask

    task automatic await_record(input int exp_pos);
        bit seen;
        int waited;
        seen = 1'b0;
        waited = 0;
        while (!seen && waited < win_len + slack) begin
            step();
            @(negedge clk);
            waited++;
            seen = record_update;
        end
        if (!seen) begin
            errors++;
            $display("Error at %0t: record_update did not arrive within %0d cycles",
                     $time, waited);
        end else begin
            check_cycle("record_update cycle", pos, exp_pos);
        end
    endtask

    ////////////////////
    // tests
    ////////////////////

    task automatic test_idle_after_reset();
        bit strobe_seen;
        strobe_seen = 1'b0;
        @(negedge clk);
        check_decimal("window_count", window_count, expect_decimal(0, 1'b0));
        check_decimal("total_count", total_count, expect_decimal(0, 1'b0));
        check_record("record", record, expect_record(0, 0, 1'b0));
        repeat (2 * win_len) begin
            step();
            @(negedge clk);
            if (record_update) begin
                strobe_seen = 1'b1;
            end
        end
        if (strobe_seen) begin
            errors++;
            $display("Error at %0t: record_update pulsed while en was low", $time);
        end
    endtask

    task automatic test_single_window();
        start_enable();
        drive_burst(200, 0);
        await_record(win_len - 1);
        check_record("record", record, expect_record(win_edges[0], 0, win_edges[0] > 999));
        check_decimal("window_count", window_count,
                      expect_decimal(win_edges[0], win_edges[0] > 999));
    endtask

    task automatic test_consecutive_windows();
        start_enable();
        for (int w = 0; w < 3; w++) begin
            drive_burst(2000, 0);
            await_record((w + 1) * win_len - 1);
            check_record("record", record, expect_record(win_edges[w], w, win_edges[w] > 999));
            check_decimal("window_count", window_count,
                          expect_decimal(win_edges[w], win_edges[w] > 999));
            check_decimal("total_count", total_count,
                          expect_decimal(total_edges, total_edges > 999));
            // first cycle of the next window.
            step();
            @(negedge clk);
            check_decimal("window_count", window_count, expect_decimal(0, 1'b0));
        end
    endtask

    task automatic test_decimal_overflow();
        start_enable();
        drive_burst(1010, 2);
        await_record(win_len - 1);
        check_record("record", record, expect_record(win_edges[0], 0, 1'b1));
        check_decimal("window_count", window_count, expect_decimal(win_edges[0], 1'b1));
        step();
        @(negedge clk);
        check_decimal("window_count", window_count, expect_decimal(0, 1'b0));
        check_decimal("total_count", total_count, expect_decimal(total_edges, 1'b1));
        drive_burst(30, 0);
        await_record(2 * win_len - 1);
        check_record("record", record, expect_record(win_edges[1], 1, 1'b0));
        check_decimal("total_count", total_count, expect_decimal(total_edges, 1'b1));
    endtask

    task automatic test_enable_drop();
        start_enable();
        drive_burst(100, 0);
        await_record(win_len - 1);
        check_record("record", record, expect_record(win_edges[0], 0, 1'b0));
        // enough edges mid-window to set both overflow flags.
        drive_burst(1010, 2);
        repeat (guard) step();
        en <= 1'b0;
        @(negedge clk);
        check_decimal("window_count", window_count,
                      expect_decimal(win_edges[1], win_edges[1] > 999));
        check_decimal("total_count", total_count,
                      expect_decimal(total_edges, total_edges > 999));
        step();
        @(negedge clk);
        check_decimal("window_count", window_count, expect_decimal(0, 1'b0));
        check_decimal("total_count", total_count, expect_decimal(0, 1'b0));
        check_record("record", record, expect_record(0, 0, 1'b0));
        // first window after re-enable is full length.
        start_enable();
        drive_burst(50, 0);
        await_record(win_len - 1);
        check_record("record", record, expect_record(win_edges[0], 0, 1'b0));
    endtask

    ////////////////////
    // run
    ////////////////////

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Error: watchdog expired after %0d cycles, tests did not finish",
                 watchdog_cycles);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        en          = 1'b0;
        pulse       = 1'b0;
        pos         = 0;
        total_edges = 0;
        errors      = 0;
        checks      = 0;
        lfsr_state  = 32'h9a0e_6d39;
        foreach (win_edges[i]) begin
            win_edges[i] = 0;
        end
        while (rst_n !== 1'b1) begin
            step();
        end
        test_idle_after_reset();
        test_single_window();
        test_consecutive_windows();
        test_decimal_overflow();
        test_enable_drop();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- bench/pulse_counter_asserts.sv
`timescale 1ns/1ps

module pulse_counter_asserts (
    input logic                          clk,
    input logic                          rst_n,
    input logic                          en,
    input pcnt_data_pkg::decimal_count_t window_count,
    input pcnt_data_pkg::decimal_count_t total_count,
    input logic                          record_update
);

    // every display digit is a legal decimal digit.
    function automatic logic digits_valid(input pcnt_data_pkg::decimal_count_t c);
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < pcnt_cfg_pkg::max_digits; i++) begin
            if (c.display.digit[i] > 4'd9) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    // one record per window, strobe is a single cycle.
    record_update_single: assert property (
        @(posedge clk) disable iff (!rst_n) record_update |=> !record_update
    ) else $error("record_update stayed high for two cycles");

    window_digits_decimal: assert property (
        @(posedge clk) disable iff (!rst_n) digits_valid(window_count)
    ) else $error("window_count holds a digit above nine");

    total_digits_decimal: assert property (
        @(posedge clk) disable iff (!rst_n) digits_valid(total_count)
    ) else $error("total_count holds a digit above nine");

    // disabled counter sends nothing.
    no_record_when_disabled: assert property (
        @(posedge clk) disable iff (!rst_n) !en |=> !record_update
    ) else $error("record_update appeared while en was low");

endmodule

//--- bench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int half_period_ns = 5,
    parameter int reset_cycles   = 4
) (
    output logic clk,
    output logic rst_n
);

    // 10 ns period.
    initial begin
        clk = 1'b0;
        forever begin
            #(half_period_ns) clk = ~clk;
        end
    end

    // reset held low for the first rising edges.
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- hdl/pulse_counter_top.sv
`timescale 1ns/1ps

module pulse_counter_top #(
    parameter int window_cycles = pcnt_cfg_pkg::window_cycles_def,
    parameter int num_digits    = pcnt_cfg_pkg::max_digits
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          en,
    input  logic                          pulse,
    output pcnt_data_pkg::decimal_count_t window_count,
    output pcnt_data_pkg::decimal_count_t total_count,
    output pcnt_data_pkg::window_record_t record,
    output logic                          record_update
);

    logic pulse_event;
    logic update;
    logic clear;

    ////////////////////
    // front end
    ////////////////////

    pulse_edge_sync pulse_edge_sync_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .pulse       (pulse),
        .pulse_event (pulse_event)
    );

    gate_timer #(
        .window_cycles (window_cycles)
    ) gate_timer_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .en     (en),
        .update (update),
        .clear  (clear)
    );

    ////////////////////
    // counters
    ////////////////////

    // display count, cleared every window.
    bcd_counter #(
        .num_digits (num_digits)
    ) window_counter_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (en),
        .inc   (pulse_event),
        .clear (clear),
        .count (window_count)
    );

    // running total, only en low clears it.
    bcd_counter #(
        .num_digits (num_digits)
    ) total_counter_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (en),
        .inc   (pulse_event),
        .clear (1'b0),
        .count (total_count)
    );

    window_capture window_capture_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .en            (en),
        .pulse_event   (pulse_event),
        .update        (update),
        .clear         (clear),
        .window_ovf    (window_count.ovf),
        .record        (record),
        .record_update (record_update)
    );

endmodule

//--- hdl/window_capture.sv
`timescale 1ns/1ps

module window_capture (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          en,
    input  logic                          pulse_event,
    input  logic                          update,
    input  logic                          clear,
    input  logic                          window_ovf,
    output pcnt_data_pkg::window_record_t record,
    output logic                          record_update
);

    localparam int tw = pcnt_cfg_pkg::tally_width;

    logic [tw-1:0]                      tally_q;
    logic [tw-1:0]                      tally_next;
    logic [pcnt_cfg_pkg::seq_width-1:0] seq_q;

    // includes an event in the update cycle itself.
    assign tally_next = tally_q + {{(tw-1){1'b0}}, pulse_event};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tally_q       <= '0;
            seq_q         <= '0;
            record        <= '0;
            record_update <= 1'b0;
        end else if (!en) begin
            tally_q       <= '0;
            seq_q         <= '0;
            record        <= '0;
            record_update <= 1'b0;
        end else begin
            record_update <= update;
            // event in the clear cycle belongs to no window.
            if (clear) begin
                tally_q <= '0;
            end else begin
                tally_q <= tally_next;
            end
            if (update) begin
                record <= '{ovf: window_ovf, seq: seq_q, tally: tally_next};
                seq_q  <= seq_q + 1'b1;
            end
        end
    end

endmodule

//--- hdl/bcd_counter.sv
`timescale 1ns/1ps

module bcd_counter #(
    parameter int num_digits = pcnt_cfg_pkg::max_digits
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         en,
    input  logic                         inc,
    input  logic                         clear,
    output pcnt_data_pkg::decimal_count_t count
);

    pcnt_data_pkg::bcd_display_t digits_q;
    pcnt_data_pkg::bcd_display_t digits_d;
    logic                        ovf_q;

    // carry[i] feeds digit i, carry[num_digits] is the wrap out.
    logic [pcnt_cfg_pkg::max_digits:0] carry;

    ////////////////////
    // same-cycle carry
    ////////////////////

    always_comb begin
        digits_d = '0;
        carry    = '0;
        carry[0] = inc;
        for (int i = 0; i < num_digits; i++) begin
            if (carry[i]) begin
                if (digits_q.digit[i] == 4'd9) begin
                    digits_d.digit[i] = 4'd0;
                    carry[i+1]        = 1'b1;
                end else begin
                    digits_d.digit[i] = digits_q.digit[i] + 4'd1;
                end
            end else begin
                digits_d.digit[i] = digits_q.digit[i];
            end
        end
    end

    ////////////////////
    // state
    ////////////////////

    // clear wins over a coincident inc, that event is dropped.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            digits_q <= '0;
            ovf_q    <= 1'b0;
        end else if (!en || clear) begin
            digits_q <= '0;
            ovf_q    <= 1'b0;
        end else begin
            digits_q <= digits_d;
            // sticky on roll from all nines.
            if (carry[num_digits]) begin
                ovf_q <= 1'b1;
            end
        end
    end

    assign count = '{ovf: ovf_q, display: digits_q};

endmodule

//--- hdl/gate_timer.sv
`timescale 1ns/1ps

module gate_timer #(
    parameter int window_cycles = pcnt_cfg_pkg::window_cycles_def
) (
    input  logic clk,
    input  logic rst_n,
    input  logic en,
    output logic update,
    output logic clear
);

    localparam int tw = pcnt_cfg_pkg::timer_width;

    // strobe points, update one cycle ahead of clear.
    localparam logic [tw-1:0] update_at = tw'(window_cycles - 2);
    localparam logic [tw-1:0] last_cycle = tw'(window_cycles - 1);

    logic [tw-1:0] timer_q;

    // held at zero while disabled so the first window is full length.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            timer_q <= '0;
        end else if (!en) begin
            timer_q <= '0;
        end else if (timer_q == last_cycle) begin
            timer_q <= '0;
        end else begin
            timer_q <= timer_q + 1'b1;
        end
    end

    // latch the result before the window is cleared.
    assign update = en && (timer_q == update_at);
    assign clear  = en && (timer_q == last_cycle);

endmodule

//--- hdl/pulse_edge_sync.sv
`timescale 1ns/1ps

module pulse_edge_sync (
    input  logic clk,
    input  logic rst_n,
    input  logic pulse,
    output logic pulse_event
);

    // two-flop synchronizer for the raw detector pulse.
    logic [1:0] sync_ff;
    // previous synchronized level.
    logic       level_prev;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_ff <= 2'b00;
        end else begin
            sync_ff <= {sync_ff[0], pulse};
        end
    end

    // registered rising edge compare, one strobe per pulse.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            level_prev  <= 1'b0;
            pulse_event <= 1'b0;
        end else begin
            level_prev  <= sync_ff[1];
            pulse_event <= sync_ff[1] & ~level_prev;
        end
    end

endmodule

//--- hdl/pcnt_data_pkg.sv
package pcnt_data_pkg;

    // one decimal digit.
    typedef logic [3:0] bcd_digit_t;

    // display digits, digit[0] is the least significant.
    // digits above the configured count read zero.
    typedef struct packed {
        bcd_digit_t [pcnt_cfg_pkg::max_digits-1:0] digit;
    } bcd_display_t;

    // decimal count plus its sticky overflow flag, 33 bits.
    typedef struct packed {
        logic         ovf;
        bcd_display_t display;
    } decimal_count_t;

    ////////////////////
    // network upload
    ////////////////////

    // one record per window, 33 bits.
    typedef struct packed {
        logic                               ovf;
        logic [pcnt_cfg_pkg::seq_width-1:0]   seq;
        logic [pcnt_cfg_pkg::tally_width-1:0] tally;
    } window_record_t;

endpackage

//--- hdl/pcnt_cfg_pkg.sv
package pcnt_cfg_pkg;

    ////////////////////
    // measurement window
    ////////////////////

    // 80 MHz clock, 1 ms window.
    localparam int window_cycles_def = 80_000;

    // gate timer must hold window_cycles_def - 1.
    localparam int timer_width = 17;

    ////////////////////
    // count widths
    ////////////////////

    // largest decimal display supported.
    localparam int max_digits = 8;

    // binary window tally for upload, wraps modulo 2^16.
    localparam int tally_width = 16;

    // window sequence number in the upload record.
    localparam int seq_width = 16;

endpackage
